// File: testbench/tlp_testdata.txt
# test  header    user  payload_bytes  stall_percent
# header and user in hex, payload length and stall percentage in decimal
1 4a000101 11 1 0
1 4a000202 22 7 0
1 4a000303 33 12 0
2 60001004 44 13 0
2 60002005 55 16 0
2 60003006 66 28 0
2 60004007 77 45 0
2 60005008 88 100 0
3 00000009 99 0 0
3 0000000a aa 0 0
4 6000600b bb 60 50
4 4a00070c cc 5 50
4 6000800d dd 33 70
5 4a00090e ee 20 0
5 6000a00f ff 3 0
5 0000b010 01 0 0

// File: filelist.f
+incdir+design
design/tlp_pkg.sv
design/tlp_skid_buffer.sv
design/tlp_hdr_split.sv
design/tlp_payload_realign.sv
design/tlp_sb_merge.sv
design/tlp_ib2sb_top.sv
testbench/tlp_ib2sb_asserts.sv
testbench/tb_tlp_ib2sb.sv

// File: Makefile
# Verilator build and run of the TLP header converter testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_tlp_ib2sb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard design/*.svh)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)

check: run
	@grep -qx 'TESTS PASSED' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_tlp_ib2sb.sv
// ==============================
// Testbench for the TLP header converter
// Packets from the data file, scoreboard,
// random output stalls and report
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "tlp_defs.svh"

module tb_tlp_ib2sb
    import tlp_pkg::*;
();

    localparam int CLK_HALF   = 4;
    localparam int RST_CYCLES = 16;
    // Cycles allowed per beat under the heaviest stall setting
    localparam int STALL_MARGIN = 20;

    // One line of the data file
    typedef struct packed {
        int          test;
        logic [31:0] hdr;
        logic [7:0]  user;
        int          len;
        int          bp;
    } pkt_desc_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    tlp_beat_t    in_beat;
    logic         in_ready;
    logic         out_valid;
    tlp_sb_beat_t out_beat;
    logic         out_ready;

    integer       seed = 32'h781907a0;
    pkt_desc_t    descs [$];
    tlp_beat_t    in_q [$];
    tlp_sb_beat_t exp_q [$];
    logic         in_took = 1'b0;
    int           cur_bp;
    int           errors;
    int           beats_checked;
    int           wd_cycles = 0;

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    tlp_ib2sb_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    // ==============================
    // Handshake sampling
    // ==============================

    // Input transfer seen at the last rising edge
    always @(posedge clk)
    begin
        in_took <= in_valid && in_ready;
    end

    // Random stalls on the output
    always @(negedge clk)
    begin
        if (cur_bp == 0)
            out_ready = 1'b1;
        else
            out_ready = (($unsigned($random(seed)) % 100) >= cur_bp);
    end

    // Output monitor
    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready)
            check_beat(out_beat);
    end

    // Compare one output beat with the head of the scoreboard
    task automatic check_beat(input tlp_sb_beat_t got);
        tlp_sb_beat_t exp;
        assert (exp_q.size() != 0)
        else
        begin
            $display("Output beat appeared with no packet pending");
            errors++;
        end
        if (exp_q.size() != 0)
        begin
            exp = exp_q.pop_front();
            beats_checked++;
            assert (got.data === exp.data)
            else
            begin
                $display("FAILED out_beat.data got %h expected %h", got.data, exp.data);
                errors++;
            end
            assert (got.keep === exp.keep)
            else
            begin
                $display("FAILED out_beat.keep got %h expected %h", got.keep, exp.keep);
                errors++;
            end
            assert (got.last === exp.last)
            else
            begin
                $display("FAILED out_beat.last got %h expected %h", got.last, exp.last);
                errors++;
            end
            assert (got.sb === exp.sb)
            else
            begin
                $display("FAILED out_beat.sb got %h expected %h", got.sb, exp.sb);
                errors++;
            end
        end
    endtask

    // ==============================
    // Stimulus and expected beats
    // ==============================

    // Input beats and expected output beats of one packet
    task automatic build_packet(input pkt_desc_t d);
        logic [7:0]   pay [$];
        tlp_beat_t    ib;
        tlp_sb_beat_t ob;
        int           n_in;
        int           n_out;
        int           pos;
        int           i;
        int           k;
        for (i = 0; i < d.len; i++)
            pay.push_back(8'($random(seed)));
        // Header bytes first, then payload, packed from byte 0
        n_in = (d.len + `TLP_HDR_BYTES + `TLP_KEEP_W - 1) / `TLP_KEEP_W;
        for (i = 0; i < n_in; i++)
        begin
            ib      = '0;
            ib.user = d.user;
            ib.last = (i == n_in - 1);
            for (k = 0; k < `TLP_KEEP_W; k++)
            begin
                pos = `TLP_KEEP_W * i + k;
                if (pos < `TLP_HDR_BYTES)
                    ib.data[8*k +: 8] = d.hdr[8*pos +: 8];
                else if (pos < d.len + `TLP_HDR_BYTES)
                    ib.data[8*k +: 8] = pay[pos - `TLP_HDR_BYTES];
                ib.keep[k] = (pos < d.len + `TLP_HDR_BYTES);
            end
            in_q.push_back(ib);
        end
        // Payload from byte 0, one beat even with no payload
        n_out = (d.len == 0) ? 1 : (d.len + `TLP_KEEP_W - 1) / `TLP_KEEP_W;
        for (i = 0; i < n_out; i++)
        begin
            ob      = '0;
            ob.last = (i == n_out - 1);
            if (i == 0)
                ob.sb = {d.hdr, d.user};
            for (k = 0; k < `TLP_KEEP_W; k++)
            begin
                pos = `TLP_KEEP_W * i + k;
                if (pos < d.len)
                begin
                    ob.data[8*k +: 8] = pay[pos];
                    ob.keep[k]        = 1'b1;
                end
            end
            exp_q.push_back(ob);
        end
    endtask

    // Input plus output beats of a packet, for the watchdog budget
    function automatic int count_beats(input int len);
        int n_in;
        int n_out;
        n_in  = (len + `TLP_HDR_BYTES + `TLP_KEEP_W - 1) / `TLP_KEEP_W;
        n_out = (len == 0) ? 1 : (len + `TLP_KEEP_W - 1) / `TLP_KEEP_W;
        return n_in + n_out;
    endfunction

    // Descriptor lines, # starts a comment line
    task automatic load_descs();
        int          fd;
        int          n;
        string       line;
        pkt_desc_t   d;
        int          t;
        logic [31:0] h;
        logic [7:0]  u;
        int          l;
        int          b;
        fd = $fopen("testbench/tlp_testdata.txt", "r");
        assert (fd != 0)
        else
        begin
            $display("Could not open the test data file");
            errors++;
        end
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#")
                begin
                    if ($sscanf(line, "%d %h %h %d %d", t, h, u, l, b) == 5)
                    begin
                        d.test = t;
                        d.hdr  = h;
                        d.user = u;
                        d.len  = l;
                        d.bp   = b;
                        descs.push_back(d);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Hold each beat until taken, in_valid stays high inside a test
    task automatic drive_beats();
        int idx;
        idx      = 0;
        in_valid = (in_q.size() != 0);
        if (in_q.size() != 0)
            in_beat = in_q[0];
        while (idx < in_q.size())
        begin
            @(negedge clk);
            if (in_took)
            begin
                idx++;
                if (idx < in_q.size())
                    in_beat = in_q[idx];
                else
                    in_valid = 1'b0;
            end
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin : main
        int idx;
        int first;
        int tnum;
        int bp;
        int err0;
        int chk0;
        int ntests;
        int total;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_beat       = '0;
        out_ready     = 1'b1;
        cur_bp        = 0;
        errors        = 0;
        beats_checked = 0;
        ntests        = 0;
        load_descs();
        total = 0;
        foreach (descs[j])
            total += count_beats(descs[j].len);
        wd_cycles = RST_CYCLES + 100 + total * STALL_MARGIN;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        idx = 0;
        while (idx < descs.size())
        begin
            // Consecutive lines with one test number form a test
            tnum  = descs[idx].test;
            first = idx;
            bp    = 0;
            err0  = errors;
            chk0  = beats_checked;
            in_q.delete();
            while (idx < descs.size() && descs[idx].test == tnum)
            begin
                build_packet(descs[idx]);
                if (descs[idx].bp > bp)
                    bp = descs[idx].bp;
                idx++;
            end
            @(posedge clk);
            cur_bp = bp;
            @(negedge clk);
            drive_beats();
            while (exp_q.size() != 0)
                @(negedge clk);
            ntests++;
            $display("Test %0d done: %0d packets, %0d output beats, %0d errors",
                     tnum, idx - first, beats_checked - chk0, errors - err0);
        end
        // Idle time to catch stray output beats
        @(posedge clk);
        cur_bp = 0;
        repeat (20) @(negedge clk);
        $display("Summary: %0d tests, %0d beats checked, %0d errors",
                 ntests, beats_checked, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Hung run guard, budget set once the data file is read
    initial
    begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout after %0d cycles with %0d output beats still expected",
                 wd_cycles, exp_q.size());
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tlp_ib2sb_asserts.sv
// ==============================
// Handshake and side-band assertions
// for the merge stage
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tlp_ib2sb_asserts
    import tlp_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         hdr_valid,
    input logic         hdr_ready,
    input logic         data_valid,
    input logic         data_ready,
    input logic         out_valid,
    input tlp_sb_beat_t out_beat,
    input logic         out_ready
);

    // Packet start as seen on the output stream
    logic first_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            first_q <= 1'b1;
        else if (out_valid && out_ready)
            first_q <= out_beat.last;
    end

    // Stalled output keeps valid and its beat
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("Output beat changed while stalled");

    // sb is only carried by the first beat of a packet
    a_sb_zero: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !first_q |-> out_beat.sb == '0)
        else $error("Side-band field set on a continuation beat");

    // Header pop goes together with the first data beat of a packet
    a_hdr_pop: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_valid && hdr_ready |-> data_valid && data_ready && first_q)
        else $error("Header popped without a first data beat");

endmodule

// Attached to every merge stage
bind tlp_sb_merge tlp_ib2sb_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .hdr_valid  (hdr_valid),
    .hdr_ready  (hdr_ready),
    .data_valid (data_valid),
    .data_ready (data_ready),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_ready  (out_ready)
);

`default_nettype wire

// File: design/tlp_ib2sb_top.sv
// ==============================
// In-band to side-band header converter top
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "tlp_defs.svh"

module tlp_ib2sb_top
    import tlp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  tlp_beat_t    in_beat,
    output logic         in_ready,
    output logic         out_valid,
    output tlp_sb_beat_t out_beat,
    input  logic         out_ready
);

    // Input skid to split
    logic           skid_valid;
    tlp_beat_t      skid_beat;
    logic           skid_ready;
    logic           accept;
    logic           sop;

    // Header path
    logic           hdr_valid;
    tlp_hdr_item_t  hdr_item;
    logic           hdr_ready;
    logic           hdr_buf_valid;
    tlp_hdr_item_t  hdr_buf_item;
    logic           hdr_buf_ready;

    // Payload path
    logic           data_valid;
    tlp_data_beat_t data_beat;
    logic           data_ready;
    logic           data_buf_valid;
    tlp_data_beat_t data_buf_beat;
    logic           data_buf_ready;

    // ==============================
    // Input stage
    // ==============================

    tlp_skid_buffer #(
        .PAYLOAD_T (tlp_beat_t),
        .DEPTH     (1)
    ) u_in_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_beat),
        .in_ready  (in_ready),
        .out_valid (skid_valid),
        .out_data  (skid_beat),
        .out_ready (skid_ready)
    );

    tlp_hdr_split u_hdr_split (
        .clk        (clk),
        .rst_n      (rst_n),
        .skid_valid (skid_valid),
        .skid_beat  (skid_beat),
        .skid_ready (skid_ready),
        .data_ready (data_ready),
        .hdr_ready  (hdr_ready),
        .accept     (accept),
        .sop        (sop),
        .hdr_valid  (hdr_valid),
        .hdr_item   (hdr_item)
    );

    tlp_payload_realign u_realign (
        .clk       (clk),
        .rst_n     (rst_n),
        .skid_beat (skid_beat),
        .accept    (accept),
        .sop       (sop),
        .out_valid (data_valid),
        .out_data  (data_beat),
        .out_ready (data_ready)
    );

    // ==============================
    // Path buffers and merge
    // ==============================

    // Headers may run ahead of their payload
    tlp_skid_buffer #(
        .PAYLOAD_T (tlp_hdr_item_t),
        .DEPTH     (`TLP_HDR_FIFO_DEPTH)
    ) u_hdr_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (hdr_valid),
        .in_data   (hdr_item),
        .in_ready  (hdr_ready),
        .out_valid (hdr_buf_valid),
        .out_data  (hdr_buf_item),
        .out_ready (hdr_buf_ready)
    );

    tlp_skid_buffer #(
        .PAYLOAD_T (tlp_data_beat_t),
        .DEPTH     (1)
    ) u_data_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (data_valid),
        .in_data   (data_beat),
        .in_ready  (data_ready),
        .out_valid (data_buf_valid),
        .out_data  (data_buf_beat),
        .out_ready (data_buf_ready)
    );

    tlp_sb_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_valid  (hdr_buf_valid),
        .hdr_item   (hdr_buf_item),
        .hdr_ready  (hdr_buf_ready),
        .data_valid (data_buf_valid),
        .data_beat  (data_buf_beat),
        .data_ready (data_buf_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: design/tlp_sb_merge.sv
// ==============================
// Merge of buffered headers and payload
// beats into the side-band stream
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tlp_sb_merge
    import tlp_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           hdr_valid,
    input  tlp_hdr_item_t  hdr_item,
    output logic           hdr_ready,
    input  logic           data_valid,
    input  tlp_data_beat_t data_beat,
    output logic           data_ready,
    output logic           out_valid,
    output tlp_sb_beat_t   out_beat,
    input  logic           out_ready
);

    // High while the next output beat opens a packet
    logic out_sop;

    // Header present, or not needed on this beat
    logic hdr_ok;

    // ==============================
    // Handshake gating
    // ==============================

    assign hdr_ok = !out_sop || hdr_valid;

    // First beat waits for its header
    assign out_valid  = data_valid && hdr_ok;
    assign data_ready = out_ready && hdr_ok;

    // Header pops only together with a first data beat
    assign hdr_ready = out_ready && out_sop && data_valid;

    // Output beat
    always_comb
    begin
        out_beat.data = data_beat.data;
        out_beat.keep = data_beat.keep;
        out_beat.last = data_beat.last;
        // sb only on the first beat
        if (out_sop)
            out_beat.sb = hdr_item;
        else
            out_beat.sb = '0;
    end

    // Output packet start
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_sop <= 1'b1;
        else if (out_valid && out_ready)
            out_sop <= data_beat.last;
    end

endmodule

`default_nettype wire

// File: design/tlp_payload_realign.sv
// ==============================
// Payload realignment, shifts data down by
// the header size across beats, drain beat
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "tlp_defs.svh"

module tlp_payload_realign
    import tlp_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  tlp_beat_t      skid_beat,
    input  logic           accept,
    input  logic           sop,
    output logic           out_valid,
    output tlp_data_beat_t out_data,
    input  logic           out_ready
);

    // Lane split around the header
    localparam int HDR_W  = `TLP_HDR_W;
    localparam int REST_W = `TLP_DATA_W - `TLP_HDR_W;
    localparam int HDR_B  = `TLP_HDR_BYTES;
    localparam int REST_B = `TLP_KEEP_W - `TLP_HDR_BYTES;

    // Previous accepted beat
    logic [`TLP_DATA_W-1:0] prev_data;
    logic [`TLP_KEEP_W-1:0] prev_keep;

    // Leftover bytes of a finished packet still to be sent
    logic                   drain_q;

    logic [`TLP_DATA_W-1:0] join_data;
    logic [`TLP_KEEP_W-1:0] join_keep;
    logic                   tail_fits;
    logic                   must_drain;

    // ==============================
    // Drain decision
    // ==============================

    // Last beat payload fits if nothing sits above the first four bytes
    assign tail_fits = !skid_beat.keep[HDR_B];

    // Single-beat packets always drain since their first beat emits nothing
    assign must_drain = skid_beat.last && (sop || !tail_fits);

    // Continuation beats emit a joined beat, drain needs no input
    assign out_valid = (accept && !sop) || drain_q;

    // ==============================
    // Beat join
    // ==============================

    always_comb
    begin
        // Upper 12 bytes of the previous beat, then low 4 of this one
        join_data = {skid_beat.data[0 +: HDR_W], prev_data[HDR_W +: REST_W]};
        join_keep = {skid_beat.keep[0 +: HDR_B], prev_keep[HDR_B +: REST_B]};

        // Drain beat has nothing from the current input
        if (drain_q)
        begin
            join_data[REST_W +: HDR_W] = '0;
            join_keep[REST_B +: HDR_B] = '0;
        end

        // Unused bytes read as zero
        for (int i = 0; i < `TLP_KEEP_W; i++)
        begin
            if (!join_keep[i])
                join_data[8*i +: 8] = 8'h00;
        end
    end

    assign out_data.data = join_data;
    assign out_data.keep = join_keep;
    assign out_data.last = drain_q || (skid_beat.last && tail_fits);

    // Previous beat capture
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            prev_data <= skid_beat.data;
            prev_keep <= skid_beat.keep;
        end
    end

    // accept implies out_ready, so a pending drain goes out with it
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            drain_q <= 1'b0;
        else if (accept)
            drain_q <= must_drain;
        else if (drain_q && out_ready)
            drain_q <= 1'b0;
    end

endmodule

`default_nettype wire

// File: design/tlp_hdr_split.sv
// ==============================
// Packet start tracking and header extraction
// ==============================

`timescale 1ns/1ps
`default_nettype none

`include "tlp_defs.svh"

module tlp_hdr_split
    import tlp_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          skid_valid,
    input  tlp_beat_t     skid_beat,
    output logic          skid_ready,
    input  logic          data_ready,
    input  logic          hdr_ready,
    output logic          accept,
    output logic          sop,
    output logic          hdr_valid,
    output tlp_hdr_item_t hdr_item
);

    // High while the next input beat opens a packet
    logic sop_q;

    // ==============================
    // Handshake join
    // ==============================

    // A beat leaves only when both paths can take it
    assign skid_ready = hdr_ready && data_ready;
    assign accept     = skid_valid && skid_ready;
    assign sop        = sop_q;

    // ==============================
    // Header path
    // ==============================

    // One header item per packet, on its first beat
    assign hdr_valid = accept && sop_q;

    // Header is the low four bytes of the first beat
    assign hdr_item.hdr  = tlp_hdr_t'(skid_beat.data[`TLP_HDR_W-1:0]);
    assign hdr_item.user = skid_beat.user;

    // Packet start follows last on every accepted beat
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            sop_q <= 1'b1;
        else if (accept)
            sop_q <= skid_beat.last;
    end

endmodule

`default_nettype wire

// File: design/tlp_skid_buffer.sv
// ==============================
// Valid/ready register stage, one or two
// entries, payload set by a type parameter
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tlp_skid_buffer #(
    parameter type PAYLOAD_T = logic [7:0],
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  PAYLOAD_T in_data,
    output logic     in_ready,
    output logic     out_valid,
    output PAYLOAD_T out_data,
    input  logic     out_ready
);

    // A single entry must pass ready through to keep one beat per cycle
    // Two entries give a fully registered ready
    localparam bit         PASS_READY = (DEPTH == 1);
    localparam logic [1:0] FULL_CNT   = 2'(DEPTH);
    localparam logic       LAST_PTR   = 1'(DEPTH - 1);

    PAYLOAD_T   buf_q [DEPTH];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Handshakes
    assign out_valid = (count != 2'd0);
    assign in_ready  = (count != FULL_CNT) || (PASS_READY && out_ready);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head of the buffer
    assign out_data = buf_q[rd_ptr];

    // Storage, written on push only
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            buf_q[wr_ptr] <= in_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            // Wrap at the last entry, stays at 0 for one entry
            if (push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? 1'b0 : ~wr_ptr;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? 1'b0 : ~rd_ptr;
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/tlp_pkg.sv
// ==============================
// Beat, header and side-band structs
// ==============================

`default_nettype none

`include "tlp_defs.svh"

package tlp_pkg;

    // Input beat with header in-band
    typedef struct packed {
        logic [`TLP_DATA_W-1:0] data;
        logic [`TLP_KEEP_W-1:0] keep;
        logic                   last;
        logic [`TLP_USER_W-1:0] user;
    } tlp_beat_t;

    // Header fields, carried as an opaque word
    typedef struct packed {
        logic [7:0] fmt_type;
        logic [7:0] tag;
        logic [9:0] length_dw;
        logic [5:0] rsvd;
    } tlp_hdr_t;

    // One header per packet, plus the packet's user field
    typedef struct packed {
        tlp_hdr_t               hdr;
        logic [`TLP_USER_W-1:0] user;
    } tlp_hdr_item_t;

    // Payload beat after realignment
    typedef struct packed {
        logic [`TLP_DATA_W-1:0] data;
        logic [`TLP_KEEP_W-1:0] keep;
        logic                   last;
    } tlp_data_beat_t;

    // Output beat, header moved to sb
    typedef struct packed {
        logic [`TLP_DATA_W-1:0] data;
        logic [`TLP_KEEP_W-1:0] keep;
        logic                   last;
        logic [`TLP_SB_W-1:0]   sb;
    } tlp_sb_beat_t;

endpackage

`default_nettype wire

// File: design/tlp_defs.svh
// ==============================
// Width and depth defines for the in-band to
// side-band TLP header converter
// ==============================

`ifndef TLP_DEFS_SVH
`define TLP_DEFS_SVH

// Data lanes and their byte enables
`define TLP_DATA_W          128
`define TLP_KEEP_W          16

// Header size, always at byte 0 of the first beat
`define TLP_HDR_W           32
`define TLP_HDR_BYTES       4

// User field carried alongside each input beat
`define TLP_USER_W          8

// Side-band field is header then user
`define TLP_SB_W            (`TLP_HDR_W + `TLP_USER_W)

// Header buffer depth
// Two entries let a header run ahead of its payload
`define TLP_HDR_FIFO_DEPTH  2

`endif
